//--- common/video_pkg.sv
package video_pkg;

   // Widths that carry a meaning
   typedef logic [15:0] crt_cnt_t;
   typedef logic [11:0] fb_dim_t;
   typedef logic [23:0] rgb_t;
   typedef logic [31:0] reg_data_t;
   typedef logic [9:0]  reg_addr_t;
   typedef logic [63:0] lb_word_t;
   typedef logic [7:0]  pxl_rate_t;

   // Bits per pixel in the line buffer
   typedef enum logic [1:0] {
      DEPTH_32 = 2'd0,
      DEPTH_16 = 2'd1,
      DEPTH_8  = 2'd2,
      DEPTH_4  = 2'd3
   } depth_e;

   // Register word indices
   localparam reg_addr_t REG_DEPTH      = 10'd2;
   localparam reg_addr_t REG_ENABLE     = 10'd3;
   localparam reg_addr_t REG_POLARITY   = 10'd4;
   localparam reg_addr_t REG_PXLFREQ    = 10'd5;
   localparam reg_addr_t REG_FB_WIDTH   = 10'd6;
   localparam reg_addr_t REG_FB_HEIGHT  = 10'd7;
   localparam reg_addr_t REG_BG_COLOR   = 10'd9;
   localparam reg_addr_t REG_H_TOTAL    = 10'd16;
   localparam reg_addr_t REG_H_END_DISP = 10'd17;
   localparam reg_addr_t REG_H_SRT_SYNC = 10'd18;
   localparam reg_addr_t REG_H_END_SYNC = 10'd19;
   localparam reg_addr_t REG_V_TOTAL    = 10'd20;
   localparam reg_addr_t REG_V_END_DISP = 10'd21;
   localparam reg_addr_t REG_V_SRT_SYNC = 10'd22;
   localparam reg_addr_t REG_V_END_SYNC = 10'd23;

   // Reset values, 640x480 at 60 Hz
   localparam pxl_rate_t DEF_PXLFREQ    = 8'd25;
   localparam fb_dim_t   DEF_FB_WIDTH   = 12'd640;
   localparam fb_dim_t   DEF_FB_HEIGHT  = 12'd480;
   localparam rgb_t      DEF_BG_COLOR   = 24'hffffff;
   localparam logic      DEF_SYNC_POL   = 1'b1;
   localparam crt_cnt_t  DEF_H_TOTAL    = 16'd800;
   localparam crt_cnt_t  DEF_H_END_DISP = 16'd640;
   localparam crt_cnt_t  DEF_H_SRT_SYNC = 16'd656;
   localparam crt_cnt_t  DEF_H_END_SYNC = 16'd752;
   localparam crt_cnt_t  DEF_V_TOTAL    = 16'd525;
   localparam crt_cnt_t  DEF_V_END_DISP = 16'd480;
   localparam crt_cnt_t  DEF_V_SRT_SYNC = 16'd490;
   localparam crt_cnt_t  DEF_V_END_SYNC = 16'd492;

endpackage

//--- design/pxl_rate_gen.sv
`timescale 1ns/10ps

module pxl_rate_gen #(
   parameter int BASE_FREQ = 125
) (
   input  logic                 pxl_clk,
   input  logic                 rst,
   input  video_pkg::pxl_rate_t rate,
   output logic                 pxl_tick
);

   // Wide enough for a remainder plus the largest rate
   localparam int ACC_W = $clog2(BASE_FREQ + 256);

   logic [ACC_W-1:0] acc;
   logic [ACC_W-1:0] acc_nxt;

   assign acc_nxt = acc + ACC_W'(rate);

   always_ff @(posedge pxl_clk or posedge rst) begin
      if (rst) begin
         acc      <= '0;
         pxl_tick <= 1'b1;
      end else if (acc_nxt >= ACC_W'(BASE_FREQ)) begin
         acc      <= acc_nxt - ACC_W'(BASE_FREQ);
         pxl_tick <= 1'b1;
      end else begin
         acc      <= acc_nxt;
         pxl_tick <= 1'b0;
      end
   end

endmodule

//--- design/ctrl_regs.sv
`timescale 1ns/10ps

module ctrl_regs (
   input  logic                 pxl_clk,
   input  logic                 rst,
   input  logic                 reg_en,
   input  logic                 reg_we,
   input  video_pkg::reg_addr_t reg_addr,
   input  video_pkg::reg_data_t reg_wdata,
   output video_pkg::reg_data_t reg_rdata,
   input  logic                 pxl_tick,
   input  logic                 vsync_active,
   output logic                 enable,
   output video_pkg::depth_e    depth,
   output logic                 hsync_pol,
   output logic                 vsync_pol,
   output video_pkg::pxl_rate_t pxl_rate,
   output video_pkg::fb_dim_t   fb_width,
   output video_pkg::fb_dim_t   fb_height,
   output video_pkg::crt_cnt_t  h_total,
   output video_pkg::crt_cnt_t  h_end_disp,
   output video_pkg::crt_cnt_t  h_srt_sync,
   output video_pkg::crt_cnt_t  h_end_sync,
   output video_pkg::crt_cnt_t  v_total,
   output video_pkg::crt_cnt_t  v_end_disp,
   output video_pkg::crt_cnt_t  v_srt_sync,
   output video_pkg::crt_cnt_t  v_end_sync,
   output video_pkg::rgb_t      bg_color
);

   import video_pkg::*;

   rgb_t bg_pending;
   logic wr;
   logic unlocked;

   assign wr       = reg_en & reg_we;
   // Timing registers only change while the display is off
   assign unlocked = !enable;

   always_ff @(posedge pxl_clk or posedge rst) begin
      if (rst) begin
         enable     <= 1'b0;
         depth      <= DEPTH_32;
         hsync_pol  <= DEF_SYNC_POL;
         vsync_pol  <= DEF_SYNC_POL;
         pxl_rate   <= DEF_PXLFREQ;
         fb_width   <= DEF_FB_WIDTH;
         fb_height  <= DEF_FB_HEIGHT;
         bg_pending <= DEF_BG_COLOR;
         h_total    <= DEF_H_TOTAL;
         h_end_disp <= DEF_H_END_DISP;
         h_srt_sync <= DEF_H_SRT_SYNC;
         h_end_sync <= DEF_H_END_SYNC;
         v_total    <= DEF_V_TOTAL;
         v_end_disp <= DEF_V_END_DISP;
         v_srt_sync <= DEF_V_SRT_SYNC;
         v_end_sync <= DEF_V_END_SYNC;
      end else if (wr) begin
         case (reg_addr)
            REG_ENABLE:     enable     <= reg_wdata[0];
            REG_BG_COLOR:   bg_pending <= reg_wdata[23:0];
            REG_DEPTH:      if (unlocked) depth <= depth_e'(reg_wdata[1:0]);
            REG_POLARITY: begin
               if (unlocked) begin
                  vsync_pol <= reg_wdata[1];
                  hsync_pol <= reg_wdata[0];
               end
            end
            REG_PXLFREQ:    if (unlocked) pxl_rate   <= reg_wdata[7:0];
            REG_FB_WIDTH:   if (unlocked) fb_width   <= reg_wdata[11:0];
            REG_FB_HEIGHT:  if (unlocked) fb_height  <= reg_wdata[11:0];
            REG_H_TOTAL:    if (unlocked) h_total    <= reg_wdata[15:0];
            REG_H_END_DISP: if (unlocked) h_end_disp <= reg_wdata[15:0];
            REG_H_SRT_SYNC: if (unlocked) h_srt_sync <= reg_wdata[15:0];
            REG_H_END_SYNC: if (unlocked) h_end_sync <= reg_wdata[15:0];
            REG_V_TOTAL:    if (unlocked) v_total    <= reg_wdata[15:0];
            REG_V_END_DISP: if (unlocked) v_end_disp <= reg_wdata[15:0];
            REG_V_SRT_SYNC: if (unlocked) v_srt_sync <= reg_wdata[15:0];
            REG_V_END_SYNC: if (unlocked) v_end_sync <= reg_wdata[15:0];
            default: ;
         endcase
      end
   end

   // Readback, one cycle after the strobe
   always_ff @(posedge pxl_clk) begin
      if (reg_en) begin
         case (reg_addr)
            REG_DEPTH:      reg_rdata <= {30'd0, depth};
            REG_ENABLE:     reg_rdata <= {31'd0, enable};
            REG_POLARITY:   reg_rdata <= {30'd0, vsync_pol, hsync_pol};
            REG_PXLFREQ:    reg_rdata <= {24'd0, pxl_rate};
            REG_FB_WIDTH:   reg_rdata <= {20'd0, fb_width};
            REG_FB_HEIGHT:  reg_rdata <= {20'd0, fb_height};
            REG_BG_COLOR:   reg_rdata <= {8'd0, bg_color};
            REG_H_TOTAL:    reg_rdata <= {16'd0, h_total};
            REG_H_END_DISP: reg_rdata <= {16'd0, h_end_disp};
            REG_H_SRT_SYNC: reg_rdata <= {16'd0, h_srt_sync};
            REG_H_END_SYNC: reg_rdata <= {16'd0, h_end_sync};
            REG_V_TOTAL:    reg_rdata <= {16'd0, v_total};
            REG_V_END_DISP: reg_rdata <= {16'd0, v_end_disp};
            REG_V_SRT_SYNC: reg_rdata <= {16'd0, v_srt_sync};
            REG_V_END_SYNC: reg_rdata <= {16'd0, v_end_sync};
            default:        reg_rdata <= '0;
         endcase
      end
   end

   // New background color lands in vertical sync so a frame never tears
   always_ff @(posedge pxl_clk or posedge rst) begin
      if (rst) begin
         bg_color <= DEF_BG_COLOR;
      end else if (pxl_tick && (vsync_active || !enable)) begin
         bg_color <= bg_pending;
      end
   end

endmodule

//--- design/line_buffer.sv
`timescale 1ns/10ps

module line_buffer #(
   parameter int LB_ADDR_W = 12
) (
   input  logic                 pxl_clk,
   input  logic                 wr_en,
   input  logic [LB_ADDR_W-1:0] wr_addr,
   input  video_pkg::lb_word_t  wr_data,
   input  logic                 rd_en,
   input  logic [LB_ADDR_W-1:0] rd_addr,
   output video_pkg::lb_word_t  rd_data
);

   import video_pkg::*;

   lb_word_t mem [2**LB_ADDR_W];

   initial begin
      for (int i = 0; i < 2**LB_ADDR_W; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge pxl_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
      // Read data holds between pixel ticks
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

//--- scanout/crtc_timing.sv
`timescale 1ns/10ps

module crtc_timing (
   input  logic                pxl_clk,
   input  logic                rst,
   input  logic                pxl_tick,
   input  logic                enable,
   input  logic                hsync_pol,
   input  logic                vsync_pol,
   input  video_pkg::fb_dim_t  fb_width,
   input  video_pkg::fb_dim_t  fb_height,
   input  video_pkg::crt_cnt_t h_total,
   input  video_pkg::crt_cnt_t h_end_disp,
   input  video_pkg::crt_cnt_t h_srt_sync,
   input  video_pkg::crt_cnt_t h_end_sync,
   input  video_pkg::crt_cnt_t v_total,
   input  video_pkg::crt_cnt_t v_end_disp,
   input  video_pkg::crt_cnt_t v_srt_sync,
   input  video_pkg::crt_cnt_t v_end_sync,
   output logic                hsync,
   output logic                vsync,
   output logic                vsync_active,
   output logic                line_start,
   output logic                line_sel,
   output logic                fb_area,
   output logic                disp_area
);

   import video_pkg::*;

   crt_cnt_t h_cnt;
   crt_cnt_t v_cnt;
   logic     h_win;
   logic     v_win;
   logic     hsync_s2;
   logic     vsync_s2;

   // Stage 1, counters held at zero while the display is off
   always_ff @(posedge pxl_clk or posedge rst) begin
      if (rst) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (!enable) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (pxl_tick) begin
         if (h_cnt == h_total - 16'd1) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == v_total - 16'd1) ? '0 : v_cnt + 16'd1;
         end else begin
            h_cnt <= h_cnt + 16'd1;
         end
      end
   end

   assign h_win = (h_cnt >= h_srt_sync) && (h_cnt < h_end_sync);
   assign v_win = (v_cnt >= v_srt_sync) && (v_cnt < v_end_sync);

   // Start of each framebuffer row, used by the fetch side in stage 2
   assign line_start = enable && (h_cnt == '0) && (v_cnt < crt_cnt_t'(fb_height));
   assign line_sel   = v_cnt[0];

   // Stage 2 then stage 3 for sync, flags leave at stage 2
   always_ff @(posedge pxl_clk or posedge rst) begin
      if (rst) begin
         hsync_s2  <= 1'b0;
         vsync_s2  <= 1'b0;
         fb_area   <= 1'b0;
         disp_area <= 1'b0;
         hsync     <= 1'b0;
         vsync     <= 1'b0;
      end else if (pxl_tick) begin
         hsync_s2  <= enable && (h_win ? !hsync_pol : hsync_pol);
         vsync_s2  <= enable && (v_win ? !vsync_pol : vsync_pol);
         fb_area   <= enable && (h_cnt < crt_cnt_t'(fb_width))
                             && (v_cnt < crt_cnt_t'(fb_height));
         disp_area <= enable && (h_cnt < h_end_disp) && (v_cnt < v_end_disp);
         hsync     <= hsync_s2;
         vsync     <= vsync_s2;
      end
   end

   // Active level is the inverse of the polarity bit
   assign vsync_active = enable && (vsync != vsync_pol);

endmodule

//--- scanout/pixel_unpack.sv
`timescale 1ns/10ps

module pixel_unpack #(
   parameter int LB_ADDR_W = 12
) (
   input  logic                 pxl_clk,
   input  logic                 rst,
   input  logic                 pxl_tick,
   input  logic                 enable,
   input  video_pkg::depth_e    depth,
   input  video_pkg::rgb_t      bg_color,
   input  logic                 line_start,
   input  logic                 line_sel,
   input  logic                 fb_area,
   input  logic                 disp_area,
   output logic                 rd_en,
   output logic [LB_ADDR_W-1:0] rd_addr,
   input  video_pkg::lb_word_t  rd_data,
   output logic [7:0]           red,
   output logic [7:0]           green,
   output logic [7:0]           blue
);

   import video_pkg::*;

   logic [5:0] offset;
   logic [5:0] offset_s3;
   logic [6:0] step;
   logic [6:0] next_off;
   logic       fb_s3;
   logic       disp_s3;
   lb_word_t   shifted;
   rgb_t       pixel;
   rgb_t       color;

   function automatic rgb_t unpack16(input logic [15:0] p);
      return {p[15:11], p[15:13], p[10:5], p[10:9], p[4:0], p[4:2]};
   endfunction

   function automatic rgb_t unpack8(input logic [7:0] p);
      return {{2{p[7:5]}}, p[7:6], {2{p[4:2]}}, p[4:3], {4{p[1:0]}}};
   endfunction

   always_comb begin
      case (depth)
         DEPTH_32: step = 7'd32;
         DEPTH_16: step = 7'd16;
         DEPTH_8:  step = 7'd8;
         default:  step = 7'd4;
      endcase
   end

   // Carry out of the offset moves to the next word
   assign next_off = {1'b0, offset} + step;

   // Stage 2 fetch position
   always_ff @(posedge pxl_clk or posedge rst) begin
      if (rst) begin
         rd_addr <= '0;
         offset  <= '0;
      end else if (pxl_tick) begin
         if (line_start) begin
            rd_addr <= {line_sel, {(LB_ADDR_W-1){1'b0}}};
            offset  <= '0;
         end else begin
            rd_addr <= rd_addr + LB_ADDR_W'(next_off[6]);
            offset  <= next_off[5:0];
         end
      end
   end

   assign rd_en = pxl_tick && enable && fb_area;

   // Stage 3, aligned with the buffer read
   always_ff @(posedge pxl_clk or posedge rst) begin
      if (rst) begin
         offset_s3 <= '0;
         fb_s3     <= 1'b0;
         disp_s3   <= 1'b0;
      end else if (pxl_tick) begin
         offset_s3 <= offset;
         fb_s3     <= fb_area;
         disp_s3   <= disp_area;
      end
   end

   assign shifted = rd_data >> offset_s3;

   always_comb begin
      case (depth)
         DEPTH_32: pixel = shifted[23:0];
         DEPTH_16: pixel = unpack16(shifted[15:0]);
         DEPTH_8:  pixel = unpack8(shifted[7:0]);
         default:  pixel = {6{shifted[3:0]}};
      endcase
   end

   always_comb begin
      if (!disp_s3 || !enable) begin
         color = '0;
      end else if (!fb_s3) begin
         color = bg_color;
      end else begin
         color = pixel;
      end
   end

   assign red   = color[23:16];
   assign green = color[15:8];
   assign blue  = color[7:0];

endmodule

//--- design/video_unit.sv
`timescale 1ns/10ps

module video_unit #(
   parameter int LB_ADDR_W = 12,
   parameter int BASE_FREQ = 125
) (
   input  logic                 pxl_clk,
   input  logic                 rst,
   input  logic                 reg_en,
   input  logic                 reg_we,
   input  video_pkg::reg_addr_t reg_addr,
   input  video_pkg::reg_data_t reg_wdata,
   output video_pkg::reg_data_t reg_rdata,
   input  logic                 lb_we,
   input  logic [LB_ADDR_W-1:0] lb_addr,
   input  video_pkg::lb_word_t  lb_wdata,
   output logic [7:0]           red,
   output logic [7:0]           green,
   output logic [7:0]           blue,
   output logic                 hsync,
   output logic                 vsync
);

   import video_pkg::*;

   logic                 pxl_tick;
   logic                 enable;
   depth_e               depth;
   logic                 hsync_pol;
   logic                 vsync_pol;
   pxl_rate_t            pxl_rate;
   fb_dim_t              fb_width;
   fb_dim_t              fb_height;
   crt_cnt_t             h_total;
   crt_cnt_t             h_end_disp;
   crt_cnt_t             h_srt_sync;
   crt_cnt_t             h_end_sync;
   crt_cnt_t             v_total;
   crt_cnt_t             v_end_disp;
   crt_cnt_t             v_srt_sync;
   crt_cnt_t             v_end_sync;
   rgb_t                 bg_color;
   logic                 vsync_active;
   logic                 line_start;
   logic                 line_sel;
   logic                 fb_area;
   logic                 disp_area;
   logic                 rd_en;
   logic [LB_ADDR_W-1:0] rd_addr;
   lb_word_t             rd_data;

   pxl_rate_gen #(
      .BASE_FREQ (BASE_FREQ)
   ) u_rate (
      .pxl_clk  (pxl_clk),
      .rst      (rst),
      .rate     (pxl_rate),
      .pxl_tick (pxl_tick)
   );

   ctrl_regs u_regs (
      .pxl_clk      (pxl_clk),
      .rst          (rst),
      .reg_en       (reg_en),
      .reg_we       (reg_we),
      .reg_addr     (reg_addr),
      .reg_wdata    (reg_wdata),
      .reg_rdata    (reg_rdata),
      .pxl_tick     (pxl_tick),
      .vsync_active (vsync_active),
      .enable       (enable),
      .depth        (depth),
      .hsync_pol    (hsync_pol),
      .vsync_pol    (vsync_pol),
      .pxl_rate     (pxl_rate),
      .fb_width     (fb_width),
      .fb_height    (fb_height),
      .h_total      (h_total),
      .h_end_disp   (h_end_disp),
      .h_srt_sync   (h_srt_sync),
      .h_end_sync   (h_end_sync),
      .v_total      (v_total),
      .v_end_disp   (v_end_disp),
      .v_srt_sync   (v_srt_sync),
      .v_end_sync   (v_end_sync),
      .bg_color     (bg_color)
   );

   crtc_timing u_crtc (
      .pxl_clk      (pxl_clk),
      .rst          (rst),
      .pxl_tick     (pxl_tick),
      .enable       (enable),
      .hsync_pol    (hsync_pol),
      .vsync_pol    (vsync_pol),
      .fb_width     (fb_width),
      .fb_height    (fb_height),
      .h_total      (h_total),
      .h_end_disp   (h_end_disp),
      .h_srt_sync   (h_srt_sync),
      .h_end_sync   (h_end_sync),
      .v_total      (v_total),
      .v_end_disp   (v_end_disp),
      .v_srt_sync   (v_srt_sync),
      .v_end_sync   (v_end_sync),
      .hsync        (hsync),
      .vsync        (vsync),
      .vsync_active (vsync_active),
      .line_start   (line_start),
      .line_sel     (line_sel),
      .fb_area      (fb_area),
      .disp_area    (disp_area)
   );

   pixel_unpack #(
      .LB_ADDR_W (LB_ADDR_W)
   ) u_unpack (
      .pxl_clk    (pxl_clk),
      .rst        (rst),
      .pxl_tick   (pxl_tick),
      .enable     (enable),
      .depth      (depth),
      .bg_color   (bg_color),
      .line_start (line_start),
      .line_sel   (line_sel),
      .fb_area    (fb_area),
      .disp_area  (disp_area),
      .rd_en      (rd_en),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data),
      .red        (red),
      .green      (green),
      .blue       (blue)
   );

   line_buffer #(
      .LB_ADDR_W (LB_ADDR_W)
   ) u_lbuf (
      .pxl_clk (pxl_clk),
      .wr_en   (lb_we),
      .wr_addr (lb_addr),
      .wr_data (lb_wdata),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

//--- verif/video_unit_tb.sv
`timescale 1ns/10ps

module video_unit_tb;

   import video_pkg::*;

   // Small test mode
   localparam int H_TOT  = 24;
   localparam int H_DISP = 16;
   localparam int H_SS   = 18;
   localparam int H_ES   = 21;
   localparam int V_TOT  = 10;
   localparam int V_DISP = 6;
   localparam int V_SS   = 7;
   localparam int V_ES   = 8;
   localparam int FB_W   = 12;
   localparam int FB_H   = 4;
   localparam int LB_HALF = 2048;

   logic        pxl_clk;
   logic        rst;
   logic        reg_en;
   logic        reg_we;
   reg_addr_t   reg_addr;
   reg_data_t   reg_wdata;
   reg_data_t   reg_rdata;
   logic        lb_we;
   logic [11:0] lb_addr;
   lb_word_t    lb_wdata;
   logic [7:0]  red;
   logic [7:0]  green;
   logic [7:0]  blue;
   logic        hsync;
   logic        vsync;

   // Reference model state
   int          errors = 0;
   int          frames = 0;
   int          h_m = 0;
   int          v_m = 0;
   int          bpp_m = 32;
   logic        quiet = 1'b1;
   logic        check_en = 1'b0;
   logic        locked = 1'b0;
   logic        prev_vs = 1'b0;
   logic        hpol_m = 1'b1;
   logic        vpol_m = 1'b1;
   rgb_t        bg_pend_m = 24'hffffff;
   rgb_t        bg_cur_m = 24'hffffff;
   lb_word_t    lb_copy [16];
   logic [31:0] seed = 32'he7a8;

   video_unit dut (
      .pxl_clk   (pxl_clk),
      .rst       (rst),
      .reg_en    (reg_en),
      .reg_we    (reg_we),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_rdata (reg_rdata),
      .lb_we     (lb_we),
      .lb_addr   (lb_addr),
      .lb_wdata  (lb_wdata),
      .red       (red),
      .green     (green),
      .blue      (blue),
      .hsync     (hsync),
      .vsync     (vsync)
   );

   initial begin
      pxl_clk = 1'b0;
      forever #5 pxl_clk = ~pxl_clk;
   end

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("Fail at %0t: %s expected %0h got %0h", $time, name, exp, act);
      errors++;
   endtask

   task automatic end_run();
      $display("Checks finished with %0d errors", errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   endtask

   task automatic abort_wait(input string what);
      $display("Timeout while waiting for %s", what);
      errors++;
      end_run();
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
      @(posedge pxl_clk);
      #1;
      reg_en    = 1'b1;
      reg_we    = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      @(posedge pxl_clk);
      #1;
      reg_en = 1'b0;
      reg_we = 1'b0;
   endtask

   // Readback lands on the edge after the strobe
   task automatic read_check(input reg_addr_t addr, input reg_data_t exp);
      @(posedge pxl_clk);
      #1;
      reg_en   = 1'b1;
      reg_we   = 1'b0;
      reg_addr = addr;
      @(posedge pxl_clk);
      #1;
      reg_en = 1'b0;
      assert (reg_rdata == exp)
         else report_mismatch($sformatf("reg_rdata[%0d]", addr), exp, reg_rdata);
   endtask

   task automatic check_defaults();
      reg_addr_t addrs [15];
      reg_data_t vals [15];
      addrs = '{REG_DEPTH, REG_ENABLE, REG_POLARITY, REG_PXLFREQ, REG_FB_WIDTH,
                REG_FB_HEIGHT, REG_BG_COLOR, REG_H_TOTAL, REG_H_END_DISP,
                REG_H_SRT_SYNC, REG_H_END_SYNC, REG_V_TOTAL, REG_V_END_DISP,
                REG_V_SRT_SYNC, REG_V_END_SYNC};
      vals  = '{0, 0, 3, 25, 640, 480, 32'hffffff, 800, 640, 656, 752,
                525, 480, 490, 492};
      for (int i = 0; i < 15; i++) begin
         read_check(addrs[i], vals[i]);
      end
      // Unmapped indices read as zero
      read_check(10'd1, 32'd0);
      read_check(10'd100, 32'd0);
   endtask

   task automatic program_mode();
      reg_addr_t addrs [11];
      reg_data_t vals [11];
      addrs = '{REG_PXLFREQ, REG_H_TOTAL, REG_H_END_DISP, REG_H_SRT_SYNC,
                REG_H_END_SYNC, REG_V_TOTAL, REG_V_END_DISP, REG_V_SRT_SYNC,
                REG_V_END_SYNC, REG_FB_WIDTH, REG_FB_HEIGHT};
      vals  = '{125, H_TOT, H_DISP, H_SS, H_ES, V_TOT, V_DISP, V_SS, V_ES, FB_W, FB_H};
      for (int i = 0; i < 11; i++) begin
         reg_write(addrs[i], vals[i]);
         read_check(addrs[i], vals[i]);
      end
   endtask

   // Eight words at the start of each line half
   task automatic lb_fill();
      lb_word_t word;
      for (int half = 0; half < 2; half++) begin
         for (int w = 0; w < 8; w++) begin
            seed = xorshift(seed);
            word[63:32] = seed;
            seed = xorshift(seed);
            word[31:0] = seed;
            lb_copy[half * 8 + w] = word;
            @(posedge pxl_clk);
            #1;
            lb_we    = 1'b1;
            lb_addr  = 12'(half * LB_HALF + w);
            lb_wdata = word;
         end
      end
      @(posedge pxl_clk);
      #1;
      lb_we = 1'b0;
   endtask

   task automatic set_enable(input logic on, input logic chk);
      if (on) begin
         quiet = 1'b0;
         reg_write(REG_ENABLE, 32'd1);
         check_en = chk;
      end else begin
         check_en = 1'b0;
         reg_write(REG_ENABLE, 32'd0);
         // Let the sync pipeline drain
         repeat (12) @(posedge pxl_clk);
         quiet = 1'b1;
      end
   endtask

   task automatic wait_frames(input int n);
      int target;
      int cycles;
      target = frames + n;
      cycles = 0;
      while (frames < target && cycles <= 2000) begin
         @(posedge pxl_clk);
         cycles++;
      end
      if (frames < target) begin
         abort_wait("checked frames");
      end
   endtask

   task automatic wait_sync(input logic vert, input logic lvl, output int n);
      n = 0;
      while ((vert ? vsync : hsync) !== lvl && n <= 3000) begin
         @(negedge pxl_clk);
         n++;
      end
      if ((vert ? vsync : hsync) !== lvl) begin
         abort_wait(vert ? "vsync level" : "hsync level");
      end
   endtask

   // Pixel h of row v sits at h times the width within the row's half
   function automatic rgb_t expect_pixel(input int v, input int h);
      int          bitpos;
      lb_word_t    raw;
      logic [4:0]  r5;
      logic [5:0]  g6;
      logic [4:0]  b5;
      logic [8:0]  r9;
      logic [8:0]  g9;
      rgb_t        px;
      bitpos = h * bpp_m;
      raw = lb_copy[(v % 2) * 8 + bitpos / 64] >> (bitpos % 64);
      case (bpp_m)
         32: px = raw[23:0];
         16: begin
            r5 = raw[15:11];
            g6 = raw[10:5];
            b5 = raw[4:0];
            px = {r5, r5[4:2], g6, g6[5:4], b5, b5[4:2]};
         end
         8: begin
            r9 = {3{raw[7:5]}};
            g9 = {3{raw[4:2]}};
            px = {r9[8:1], g9[8:1], {4{raw[1:0]}}};
         end
         default: px = {6{raw[3:0]}};
      endcase
      return px;
   endfunction

   task automatic check_sample();
      logic exp_hs;
      logic exp_vs;
      rgb_t exp_rgb;
      exp_hs = (h_m >= H_SS && h_m < H_ES) ? !hpol_m : hpol_m;
      exp_vs = (v_m >= V_SS && v_m < V_ES) ? !vpol_m : vpol_m;
      if (h_m >= H_DISP || v_m >= V_DISP) begin
         exp_rgb = '0;
      end else if (h_m >= FB_W || v_m >= FB_H) begin
         exp_rgb = bg_cur_m;
      end else begin
         exp_rgb = expect_pixel(v_m, h_m);
      end
      assert (hsync == exp_hs) else report_mismatch("hsync", 32'(exp_hs), 32'(hsync));
      assert (vsync == exp_vs) else report_mismatch("vsync", 32'(exp_vs), 32'(vsync));
      assert ({red, green, blue} == exp_rgb)
         else report_mismatch("rgb", 32'(exp_rgb), 32'({red, green, blue}));
   endtask

   // Model counter locks to the first vsync start after enabling
   always @(negedge pxl_clk) begin
      if (!check_en) begin
         locked = 1'b0;
      end else if (!locked && vsync == !vpol_m && prev_vs != !vpol_m) begin
         locked = 1'b1;
         h_m = 0;
         v_m = V_SS;
      end
      if (locked) begin
         if (h_m == 0 && v_m == V_SS) begin
            bg_cur_m = bg_pend_m;
            frames++;
         end
         check_sample();
         if (h_m == H_TOT - 1) begin
            h_m = 0;
            v_m = (v_m == V_TOT - 1) ? 0 : v_m + 1;
         end else begin
            h_m = h_m + 1;
         end
      end
      prev_vs = vsync;
   end

   // Outputs stay low while the display is off
   assert property (@(negedge pxl_clk) disable iff (rst) quiet |-> !hsync)
      else report_mismatch("hsync", 32'd0, 32'(hsync));
   assert property (@(negedge pxl_clk) disable iff (rst) quiet |-> !vsync)
      else report_mismatch("vsync", 32'd0, 32'(vsync));
   assert property (@(negedge pxl_clk) disable iff (rst)
                    quiet |-> ({red, green, blue} == 24'd0))
      else report_mismatch("rgb", 32'd0, 32'({red, green, blue}));

   initial begin
      int n;
      int n1;
      int n2;
      rst       = 1'b1;
      reg_en    = 1'b0;
      reg_we    = 1'b0;
      reg_addr  = '0;
      reg_wdata = '0;
      lb_we     = 1'b0;
      lb_addr   = '0;
      lb_wdata  = '0;
      repeat (8) @(posedge pxl_clk);
      #1;
      rst = 1'b0;

      check_defaults();
      lb_fill();
      program_mode();
      reg_write(REG_BG_COLOR, 32'h123456);
      bg_pend_m = 24'h123456;
      bg_cur_m  = 24'h123456;
      read_check(REG_BG_COLOR, 32'h123456);

      // Timing and depth are locked once enabled
      set_enable(1'b1, 1'b1);
      reg_write(REG_H_TOTAL, 32'd99);
      read_check(REG_H_TOTAL, 32'(H_TOT));
      reg_write(REG_DEPTH, 32'd1);
      read_check(REG_DEPTH, 32'd0);
      wait_frames(2);

      // New background written mid-frame shows after the next vsync
      wait_sync(1'b1, vpol_m, n);
      reg_write(REG_BG_COLOR, 32'h00ff80);
      bg_pend_m = 24'h00ff80;
      wait_frames(2);
      read_check(REG_BG_COLOR, 32'h00ff80);

      for (int code = 1; code < 4; code++) begin
         set_enable(1'b0, 1'b0);
         reg_write(REG_DEPTH, 32'(code));
         bpp_m = 32 >> code;
         set_enable(1'b1, 1'b1);
         wait_frames(2);
      end

      // Positive sync polarity
      set_enable(1'b0, 1'b0);
      reg_write(REG_POLARITY, 32'd0);
      hpol_m = 1'b0;
      vpol_m = 1'b0;
      set_enable(1'b1, 1'b1);
      wait_frames(2);

      // One tick in five
      set_enable(1'b0, 1'b0);
      reg_write(REG_PXLFREQ, 32'd25);
      set_enable(1'b1, 1'b0);
      wait_sync(1'b0, hpol_m, n);
      wait_sync(1'b0, !hpol_m, n);
      wait_sync(1'b0, hpol_m, n1);
      wait_sync(1'b0, !hpol_m, n2);
      assert (n1 + n2 == 5 * H_TOT)
         else report_mismatch("hsync period", 32'(5 * H_TOT), 32'(n1 + n2));

      end_run();
   end

endmodule

//--- verilog.f
common/video_pkg.sv
design/pxl_rate_gen.sv
design/ctrl_regs.sv
design/line_buffer.sv
scanout/crtc_timing.sv
scanout/pixel_unpack.sv
design/video_unit.sv
verif/video_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compiles the file list with Verilator and runs the video_unit testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module video_unit_tb \
   -Mdir obj_dir -o sim_video_unit \
   && out="$(./obj_dir/sim_video_unit)" \
   && echo "$out" \
   && grep -qx "NO ERRORS" <<< "$out" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
